// File: cu_defines.svh
////////////////////
// Control unit decision slice
// Shared widths, microprogram depth and host register offsets
////////////////////

`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// Macro-instruction and condition flags
`define CU_IR_W          16
`define CU_FLAG_W        4
// Micro-PC is one bit wider so it can sit one past the last word
`define CU_UPC_W         5
`define CU_USTORE_DEPTH  16
// AXI4-Lite host bus
`define CU_AXI_AW        5
`define CU_AXI_DW        32
// Host register offsets
`define CU_REG_IR        5'h00
`define CU_REG_FLAGS     5'h04
`define CU_REG_CTRL      5'h08
`define CU_REG_STATUS    5'h0C
`define CU_REG_SKIPMASK  5'h10

`endif

// File: cu_pkg.sv
////////////////////
// Control unit types
// IR views, flag word, micro-instruction format and skip condition codes
////////////////////

`default_nettype none

`include "cu_defines.svh"

package cu_pkg;

   // Branch view of the IR
   // Bit 4 inverts the test, bits 3..0 pick the flags (N Z L V)
   typedef struct packed {
      logic [`CU_IR_W-6:0]   rsvd;
      logic                  negate;
      logic [`CU_FLAG_W-1:0] mask;
   } ir_branch_t;

   // Condition view of the IR
   // Bits 9..3 are condition lines 7..1
   typedef struct packed {
      logic [`CU_IR_W-11:0] rsvd_hi;
      logic [7:1]           line;
      logic [2:0]           rsvd_lo;
   } ir_cond_t;

   // Bits 3 and 4 belong to both views
   typedef union packed {
      ir_branch_t          br;
      ir_cond_t            cnd;
      logic [`CU_IR_W-1:0] raw;
   } ir_word_u;

   // V sits at bit 0, N at bit 3
   typedef struct packed {
      logic n;
      logic z;
      logic l;
      logic v;
   } flags_t;

   // One word of the microprogram
   typedef struct packed {
      logic [3:0] cond;
      logic       last;
   } uinstr_t;

   // Skip condition codes
   // Low half tests IR lines, high half tests flags and the branch word
   // Code 9 is also a never, it has no name of its own
   typedef enum logic [3:0] {
      COND_NEVER    = 4'd0,
      COND_IR1      = 4'd1,
      COND_IR2      = 4'd2,
      COND_IR3      = 4'd3,
      COND_IR4      = 4'd4,
      COND_IR5      = 4'd5,
      COND_IR6      = 4'd6,
      COND_IR7      = 4'd7,
      COND_NEVER_HI = 4'd8,
      COND_FV       = 4'd10,
      COND_FL       = 4'd11,
      COND_FZ       = 4'd12,
      COND_FN       = 4'd13,
      COND_ALWAYS   = 4'd14,
      COND_BRANCH   = 4'd15
   } cond_e;

endpackage

`default_nettype wire

// File: cu_ctl_if.sv
////////////////////
// Control unit internal bundle
// Host settings out of the register block, run status back from the sequencer
////////////////////

`default_nettype none

`include "cu_defines.svh"

interface cu_ctl_if (input wire logic clk4);
   import cu_pkg::*;

   // From the register block
   ir_word_u                     ir;
   flags_t                       flags;
   logic                         skip_ext;
   // One cycle wide
   logic                         start;

   // From the sequencer
   logic                         busy;
   logic [`CU_USTORE_DEPTH-1:0]  skip_mask;
   logic [`CU_UPC_W-1:0]         steps_executed;

   modport regs_mp (
      input  clk4, busy, skip_mask, steps_executed,
      output ir, flags, skip_ext, start
   );

   modport seq_mp (
      input  clk4, start,
      output busy, skip_mask, steps_executed
   );

   // Skip unit only looks at the decision inputs
   modport skip_mp (
      input  clk4, ir, flags, skip_ext
   );

endinterface

`default_nettype wire

// File: skip_unit.sv
////////////////////
// Skip unit
// Evaluates a micro-instruction's skip condition against the IR and flags
// and holds the decision for one micro-instruction
////////////////////

`default_nettype none

module skip_unit (
   input  wire logic       clk4,
   input  wire logic       arst_n,
   cu_ctl_if.skip_mp       ctl,
   input  wire logic [3:0] cond,
   input  wire logic       eval,
   output logic            skip
);
   import cu_pkg::*;

   logic       branch_hit;
   logic [7:0] lo_lines;
   logic [7:0] hi_lines;
   logic       skip_lo;
   logic       skip_hi;
   logic       skip_d;

   ////////////////////
   // Branch test
   ////////////////////

   // Any selected flag set, optionally inverted by the negate bit
   assign branch_hit = (|(ctl.flags & ctl.ir.br.mask)) ^ ctl.ir.br.negate;

   ////////////////////
   // Condition selection
   ////////////////////

   always_comb begin
      // Low half, slot 0 never skips
      lo_lines = '0;
      lo_lines[7:1] = ctl.ir.cnd.line;
      lo_lines[3'(COND_NEVER)] = 1'b0;

      // High half, slots 0 and 1 never skip
      hi_lines = '0;
      hi_lines[3'(COND_NEVER_HI)] = 1'b0;
      hi_lines[3'(COND_FV)] = ctl.flags.v;
      hi_lines[3'(COND_FL)] = ctl.flags.l;
      hi_lines[3'(COND_FZ)] = ctl.flags.z;
      hi_lines[3'(COND_FN)] = ctl.flags.n;
      hi_lines[3'(COND_ALWAYS)] = 1'b1;
      hi_lines[3'(COND_BRANCH)] = branch_hit;
   end

   // Two eight-way selections on the low code bits
   assign skip_lo = lo_lines[cond[2:0]];
   assign skip_hi = hi_lines[cond[2:0]];

   // Top code bit picks the half, external request forces a skip
   assign skip_d = (cond[3] ? skip_hi : skip_lo) | ctl.skip_ext;

   ////////////////////
   // Decision register
   ////////////////////

   // Loaded on the evaluate strobe, held for the rest of the step
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         skip <= 1'b0;
      end else if (eval) begin
         skip <= skip_d;
      end
   end

   // First clock out of reset sees no pending skip
   a_skip_clear_after_reset: assert property (
      @(posedge clk4) $rose(arst_n) |-> !skip
   );

endmodule

`default_nettype wire

// File: microcode_store.sv
////////////////////
// Microcode store
// Fixed microprogram ROM with a registered read port
////////////////////

`default_nettype none

`include "cu_defines.svh"

module microcode_store (
   input  wire logic                 clk4,
   input  wire logic                 arst_n,
   input  wire logic [`CU_UPC_W-1:0] addr,
   output cu_pkg::uinstr_t           word
);
   import cu_pkg::*;

   localparam int MA_W = $clog2(`CU_USTORE_DEPTH);

   uinstr_t rom [`CU_USTORE_DEPTH];

   // Word a tests condition a
   // Only the final word ends the program
   for (genvar a = 0; a < `CU_USTORE_DEPTH; a++) begin : g_rom
      assign rom[a] = '{cond: 4'(a), last: (a == `CU_USTORE_DEPTH - 1)};
   end

   // One cycle read latency
   // Out of range addresses read as a never-skip terminator
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         word <= '{cond: COND_NEVER, last: 1'b0};
      end else if (addr < `CU_USTORE_DEPTH) begin
         word <= rom[addr[MA_W-1:0]];
      end else begin
         word <= '{cond: COND_NEVER, last: 1'b1};
      end
   end

endmodule

`default_nettype wire

// File: microsequencer.sv
////////////////////
// Microsequencer
// Steps the micro-PC through the microprogram, applies skips,
// decides termination and records the skip trace and step count
////////////////////

`default_nettype none

`include "cu_defines.svh"

module microsequencer (
   input  wire logic                  clk4,
   input  wire logic                  arst_n,
   cu_ctl_if.seq_mp                   ctl,
   output logic [`CU_UPC_W-1:0]       fetch_addr,
   input  wire cu_pkg::uinstr_t       word,
   output logic                       eval,
   input  wire logic                  skip
);

   // Idle, address the store, then evaluate and advance
   typedef enum logic [1:0] {
      S_IDLE,
      S_FETCH,
      S_EXEC
   } state_e;

   localparam int MA_W = $clog2(`CU_USTORE_DEPTH);
   localparam logic [`CU_UPC_W-1:0] UPC_END = `CU_USTORE_DEPTH;

   state_e                      state;
   // Set in the second S_EXEC cycle when the skip decision is valid
   logic                        adv;
   logic                        last_q;
   logic [`CU_UPC_W-1:0]        upc;
   logic [`CU_UPC_W-1:0]        upc_inc;
   logic [`CU_USTORE_DEPTH-1:0] mask;
   logic [`CU_UPC_W-1:0]        steps;
   logic                        done;

   // Step over the next word when the skip is taken
   assign upc_inc = upc + {{(`CU_UPC_W-2){1'b0}}, skip, !skip};

   // Stop on a last word or when running off the end
   assign done = last_q || (upc_inc >= UPC_END);

   assign fetch_addr = upc;
   assign eval = (state == S_EXEC) && !adv;

   assign ctl.busy = (state != S_IDLE);
   assign ctl.skip_mask = mask;
   assign ctl.steps_executed = steps;

   ////////////////////
   // Step FSM
   ////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         state <= S_IDLE;
         adv <= 1'b0;
         last_q <= 1'b0;
         upc <= '0;
         mask <= '0;
         steps <= '0;
      end else begin
         unique case (state)
            S_IDLE: begin
               // New run clears the trace and the count
               if (ctl.start) begin
                  upc <= '0;
                  mask <= '0;
                  steps <= '0;
                  state <= S_FETCH;
               end
            end
            S_FETCH: begin
               // Store samples upc at the end of this cycle
               adv <= 1'b0;
               state <= S_EXEC;
            end
            S_EXEC: begin
               if (!adv) begin
                  // Word is valid and the skip unit loads on eval
                  last_q <= word.last;
                  adv <= 1'b1;
               end else begin
                  steps <= steps + 1'b1;
                  if (skip) begin
                     mask[upc[MA_W-1:0]] <= 1'b1;
                  end
                  // A skip from the final word would pass the end
                  upc <= (upc_inc > UPC_END) ? UPC_END : upc_inc;
                  state <= done ? S_IDLE : S_FETCH;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   // Register block never starts a running program
   // and a start always raises busy on the next clock
   a_start_only_idle: assert property (
      @(posedge clk4) disable iff (!arst_n)
      ctl.start |-> !ctl.busy ##1 ctl.busy
   );

   // A running program only addresses words inside the store
   // and the end position is at most one past the last word
   a_upc_in_range: assert property (
      @(posedge clk4) disable iff (!arst_n)
      (upc <= UPC_END) && (!ctl.busy || (upc < UPC_END))
   );

endmodule

`default_nettype wire

// File: cu_axil_regs.sv
////////////////////
// Host register block
// AXI4-Lite slave holding IR, flags and skip_ext
// Issues the start pulse and reports the run status
////////////////////

`default_nettype none

`include "cu_defines.svh"

module cu_axil_regs (
   input  wire logic                    clk4,
   input  wire logic                    arst_n,
   input  wire logic [`CU_AXI_AW-1:0]   awaddr,
   input  wire logic                    awvalid,
   output logic                         awready,
   input  wire logic [`CU_AXI_DW-1:0]   wdata,
   input  wire logic [`CU_AXI_DW/8-1:0] wstrb,
   input  wire logic                    wvalid,
   output logic                         wready,
   output logic [1:0]                   bresp,
   output logic                         bvalid,
   input  wire logic                    bready,
   input  wire logic [`CU_AXI_AW-1:0]   araddr,
   input  wire logic                    arvalid,
   output logic                         arready,
   output logic [`CU_AXI_DW-1:0]        rdata,
   output logic [1:0]                   rresp,
   output logic                         rvalid,
   input  wire logic                    rready,
   cu_ctl_if.regs_mp                    ctl
);
   import cu_pkg::*;

   localparam logic [1:0] RESP_OKAY = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   ir_word_u              ir_q;
   flags_t                flags_q;
   logic                  skip_ext_q;
   logic                  start_q;
   logic                  wr_go;
   logic                  wr_open;
   logic                  wr_mapped;
   logic                  rd_go;
   logic                  rd_mapped;
   logic [`CU_AXI_DW-1:0] rd_word;

   // Address and data are taken together, only with no response pending
   assign wr_go = awvalid && wvalid && !bvalid;
   assign awready = wr_go;
   assign wready = wr_go;
   // Settings are frozen while a program runs
   assign wr_open = wr_go && !ctl.busy;

   // One read in flight
   assign rd_go = arvalid && !rvalid;
   assign arready = rd_go;

   assign ctl.ir = ir_q;
   assign ctl.flags = flags_q;
   assign ctl.skip_ext = skip_ext_q;
   assign ctl.start = start_q;

   ////////////////////
   // Address decode
   ////////////////////

   always_comb begin
      case (awaddr)
         `CU_REG_IR, `CU_REG_FLAGS, `CU_REG_CTRL,
         `CU_REG_STATUS, `CU_REG_SKIPMASK: wr_mapped = 1'b1;
         default: wr_mapped = 1'b0;
      endcase
   end

   always_comb begin
      rd_word = '0;
      rd_mapped = 1'b1;
      case (araddr)
         `CU_REG_IR: rd_word[`CU_IR_W-1:0] = ir_q.raw;
         `CU_REG_FLAGS: rd_word[`CU_FLAG_W-1:0] = flags_q;
         // Start reads back as 0
         `CU_REG_CTRL: rd_word[1] = skip_ext_q;
         `CU_REG_STATUS: begin
            rd_word[0] = ctl.busy;
            rd_word[8 +: `CU_UPC_W] = ctl.steps_executed;
         end
         `CU_REG_SKIPMASK: rd_word[`CU_USTORE_DEPTH-1:0] = ctl.skip_mask;
         default: rd_mapped = 1'b0;
      endcase
   end

   ////////////////////
   // Host registers
   ////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         ir_q <= '0;
         flags_q <= '0;
         skip_ext_q <= 1'b0;
         start_q <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (wr_open) begin
            case (awaddr)
               `CU_REG_IR: begin
                  // Byte lanes honoured
                  if (wstrb[0]) begin
                     ir_q.raw[7:0] <= wdata[7:0];
                  end
                  if (wstrb[1]) begin
                     ir_q.raw[15:8] <= wdata[15:8];
                  end
               end
               `CU_REG_FLAGS: begin
                  if (wstrb[0]) begin
                     flags_q <= wdata[`CU_FLAG_W-1:0];
                  end
               end
               `CU_REG_CTRL: begin
                  start_q <= wdata[0];
                  skip_ext_q <= wdata[1];
               end
               default: begin
                  // Read-only and unmapped addresses keep no state
               end
            endcase
         end
      end
   end

   ////////////////////
   // Responses
   ////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         bvalid <= 1'b0;
         bresp <= RESP_OKAY;
         rvalid <= 1'b0;
      end else begin
         // Ignored busy writes still answer OKAY
         if (wr_go) begin
            bvalid <= 1'b1;
            bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (rd_go) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // Read data captured with the address, held while rready is low
   always_ff @(posedge clk4) begin
      if (rd_go) begin
         rdata <= rd_word;
         rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
      end
   end

   a_bvalid_hold: assert property (
      @(posedge clk4) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(bresp)
   );

endmodule

`default_nettype wire

// File: control_unit_top.sv
////////////////////
// Control unit decision slice, top level
// Host registers, microsequencer, microcode store and skip unit
////////////////////

`default_nettype none

`include "cu_defines.svh"

module control_unit_top (
   input  wire logic                    clk4,
   input  wire logic                    arst_n,
   input  wire logic [`CU_AXI_AW-1:0]   awaddr,
   input  wire logic                    awvalid,
   output logic                         awready,
   input  wire logic [`CU_AXI_DW-1:0]   wdata,
   input  wire logic [`CU_AXI_DW/8-1:0] wstrb,
   input  wire logic                    wvalid,
   output logic                         wready,
   output logic [1:0]                   bresp,
   output logic                         bvalid,
   input  wire logic                    bready,
   input  wire logic [`CU_AXI_AW-1:0]   araddr,
   input  wire logic                    arvalid,
   output logic                         arready,
   output logic [`CU_AXI_DW-1:0]        rdata,
   output logic [1:0]                   rresp,
   output logic                         rvalid,
   input  wire logic                    rready
);
   import cu_pkg::*;

   // Sequencer to store and skip unit
   logic [`CU_UPC_W-1:0] fetch_addr;
   uinstr_t              uword;
   logic                 eval;
   logic                 skip;

   cu_ctl_if ctl0 (.clk4(clk4));

   cu_axil_regs regs0 (
      .clk4    (clk4),
      .arst_n  (arst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .ctl     (ctl0.regs_mp)
   );

   microsequencer seq0 (
      .clk4       (clk4),
      .arst_n     (arst_n),
      .ctl        (ctl0.seq_mp),
      .fetch_addr (fetch_addr),
      .word       (uword),
      .eval       (eval),
      .skip       (skip)
   );

   microcode_store store0 (
      .clk4   (clk4),
      .arst_n (arst_n),
      .addr   (fetch_addr),
      .word   (uword)
   );

   skip_unit skip0 (
      .clk4   (clk4),
      .arst_n (arst_n),
      .ctl    (ctl0.skip_mp),
      .cond   (uword.cond),
      .eval   (eval),
      .skip   (skip)
   );

endmodule

`default_nettype wire

// File: tb_control_unit.sv
////////////////////
// Control unit decision slice, testbench
// Drives the AXI4-Lite host port with LFSR stimulus and checks
// the skip trace and step count against a model of the microprogram
////////////////////

`default_nettype none

`include "cu_defines.svh"

module tb_control_unit;

   localparam int WAIT_LIMIT = 100;

   logic        clk4;
   logic        arst_n;
   logic [4:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [4:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   logic [31:0] lfsr;
   int          errors;
   int          err_mark;
   int          tests_run;
   int          tests_failed;

   control_unit_top dut0 (.*);

   always #5 clk4 = ~clk4;

   ////////////////////
   // Helpers
   ////////////////////

   task automatic abort_run(input string what);
      $display("%s at time %0t", what, $time);
      $display("Test failed");
      $finish;
   endtask

   // Galois LFSR with taps 32 22 2 1
   // Stepped once for each bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      errors++;
   endtask

   // Address and data go together and the B response follows
   task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
      int n;
      @(posedge clk4);
      #1;
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awvalid = 1'b1;
      wvalid = 1'b1;
      bready = 1'b1;
      n = 0;
      @(negedge clk4);
      while (!(awready && wready)) begin
         n++;
         if (n > WAIT_LIMIT) abort_run("Write address and data were never accepted");
         @(negedge clk4);
      end
      @(posedge clk4);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      n = 0;
      @(negedge clk4);
      while (!bvalid) begin
         n++;
         if (n > WAIT_LIMIT) abort_run("No write response arrived");
         @(negedge clk4);
      end
      resp = bresp;
      @(posedge clk4);
      #1;
      bready = 1'b0;
   endtask

   // Hold keeps rready low for that many cycles after rvalid
   task automatic axi_read(input logic [4:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
      int n;
      @(posedge clk4);
      #1;
      araddr = addr;
      arvalid = 1'b1;
      rready = 1'b0;
      n = 0;
      @(negedge clk4);
      while (!arready) begin
         n++;
         if (n > WAIT_LIMIT) abort_run("Read address was never accepted");
         @(negedge clk4);
      end
      @(posedge clk4);
      #1;
      arvalid = 1'b0;
      n = 0;
      @(negedge clk4);
      while (!rvalid) begin
         n++;
         if (n > WAIT_LIMIT) abort_run("No read data arrived");
         @(negedge clk4);
      end
      data = rdata;
      resp = rresp;
      for (int i = 0; i < hold; i++) begin
         @(negedge clk4);
         if (!rvalid) begin
            $display("rvalid dropped before rready at time %0t", $time);
            errors++;
         end
         if (rdata !== data) report_mismatch("rdata held", rdata, data);
      end
      @(posedge clk4);
      #1;
      rready = 1'b1;
      @(posedge clk4);
      #1;
      rready = 1'b0;
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [1:0] r;
      axi_write(addr, data, strb, r);
      if (r !== 2'b00) report_mismatch("bresp", 32'(r), 32'h0);
   endtask

   task automatic check_reg(input string name, input logic [4:0] addr,
                            input logic [31:0] exp, input int hold);
      logic [31:0] d;
      logic [1:0]  r;
      axi_read(addr, hold, d, r);
      if (r !== 2'b00) report_mismatch({name, " rresp"}, 32'(r), 32'h0);
      if (d !== exp) report_mismatch(name, d, exp);
   endtask

   // Busy must be seen high first and is then polled until it falls
   task automatic wait_idle();
      logic [31:0] st;
      logic [1:0]  r;
      int          n;
      axi_read(`CU_REG_STATUS, 0, st, r);
      if (st[0] !== 1'b1) begin
         $display("Busy was not set after a start write at time %0t", $time);
         errors++;
      end
      n = 0;
      while (st[0] === 1'b1) begin
         n++;
         if (n > WAIT_LIMIT) abort_run("Busy never fell, the microprogram did not finish");
         axi_read(`CU_REG_STATUS, 0, st, r);
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Word a tests condition a
   // A taken skip steps over one word
   function automatic void model_run(input logic [15:0] ir, input logic [3:0] fl,
                                     input logic sx, output logic [15:0] mask,
                                     output int steps);
      int   a;
      logic hit;
      mask = '0;
      steps = 0;
      a = 0;
      while (a < 16) begin
         if (a == 0 || a == 8 || a == 9) hit = 1'b0;
         else if (a <= 7) hit = ir[a+2];
         else if (a <= 13) hit = fl[a-10];
         else if (a == 14) hit = 1'b1;
         else hit = (|(fl & ir[3:0])) ^ ir[4];
         hit = hit | sx;
         steps++;
         if (hit) mask[a] = 1'b1;
         // Word 15 is last so both of its successors end the run
         a = hit ? a + 2 : a + 1;
      end
   endfunction

   task automatic run_case(input logic [15:0] ir, input logic [3:0] fl,
                           input logic sx, input int hold);
      logic [15:0] m;
      int          s;
      write_reg(`CU_REG_IR, {16'h0, ir}, 4'b0011);
      write_reg(`CU_REG_FLAGS, {28'h0, fl}, 4'b0001);
      write_reg(`CU_REG_CTRL, {30'h0, sx, 1'b1}, 4'b0001);
      wait_idle();
      model_run(ir, fl, sx, m, s);
      check_reg("SKIPMASK", `CU_REG_SKIPMASK, {16'h0, m}, hold);
      check_reg("STATUS", `CU_REG_STATUS, 32'(s) << 8, hold);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors > err_mark) begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_mark);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      logic [31:0] v;
      logic [31:0] f;
      logic [31:0] sb;
      logic [31:0] d;
      logic [1:0]  r;
      logic [15:0] exp_ir;
      logic [3:0]  exp_fl;
      logic [15:0] m;
      int          s;

      clk4 = 1'b0;
      arst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      lfsr = 32'h8863;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (2) @(posedge clk4);
      #1;
      arst_n = 1'b1;

      // Idle status and unmapped decode
      err_mark = errors;
      check_reg("STATUS", `CU_REG_STATUS, 32'h0, 0);
      check_reg("SKIPMASK", `CU_REG_SKIPMASK, 32'h0, 0);
      axi_read(5'h14, 0, d, r);
      if (r !== 2'b10) report_mismatch("rresp unmapped", 32'(r), 32'h2);
      finish_test("reset");

      // Byte lanes on IR and lane 0 on FLAGS
      // Both are frozen while busy
      err_mark = errors;
      exp_ir = '0;
      exp_fl = '0;
      repeat (8) begin
         v = take_bits(16);
         sb = take_bits(2);
         write_reg(`CU_REG_IR, v, {2'b00, sb[1:0]});
         if (sb[0]) exp_ir[7:0] = v[7:0];
         if (sb[1]) exp_ir[15:8] = v[15:8];
         check_reg("IR", `CU_REG_IR, {16'h0, exp_ir}, 0);
         f = take_bits(4);
         sb = take_bits(1);
         write_reg(`CU_REG_FLAGS, f, {3'b000, sb[0]});
         if (sb[0]) exp_fl = f[3:0];
         check_reg("FLAGS", `CU_REG_FLAGS, {28'h0, exp_fl}, 0);
      end
      write_reg(`CU_REG_CTRL, 32'h1, 4'b0001);
      write_reg(`CU_REG_IR, {16'h0, ~exp_ir}, 4'b0011);
      write_reg(`CU_REG_FLAGS, {28'h0, ~exp_fl}, 4'b0001);
      wait_idle();
      check_reg("IR", `CU_REG_IR, {16'h0, exp_ir}, 0);
      check_reg("FLAGS", `CU_REG_FLAGS, {28'h0, exp_fl}, 0);
      finish_test("register access");

      // With everything zero only the always word skips
      err_mark = errors;
      model_run(16'h0, 4'h0, 1'b0, m, s);
      if (m !== 16'h4000) report_mismatch("model mask", 32'(m), 32'h4000);
      if (s !== 15) report_mismatch("model steps", 32'(s), 32'd15);
      run_case(16'h0, 4'h0, 1'b0, 0);
      finish_test("zero program");

      err_mark = errors;
      repeat (40) begin
         v = take_bits(16);
         f = take_bits(4);
         run_case(v[15:0], f[3:0], 1'b0, 0);
      end
      finish_test("random runs");

      // External skip makes every executed word skip
      err_mark = errors;
      v = take_bits(16);
      f = take_bits(4);
      model_run(v[15:0], f[3:0], 1'b1, m, s);
      if (m !== 16'h5555) report_mismatch("model mask", 32'(m), 32'h5555);
      if (s !== 8) report_mismatch("model steps", 32'(s), 32'd8);
      run_case(v[15:0], f[3:0], 1'b1, 0);
      finish_test("external skip");

      // Late rready on the result reads
      err_mark = errors;
      repeat (6) begin
         v = take_bits(16);
         f = take_bits(4);
         sb = take_bits(3);
         run_case(v[15:0], f[3:0], 1'b0, int'(sb[2:0]) + 1);
      end
      finish_test("read back-pressure");

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
cu_pkg.sv
cu_ctl_if.sv
skip_unit.sv
microcode_store.sv
microsequencer.sv
cu_axil_regs.sv
control_unit_top.sv
tb_control_unit.sv

// File: Makefile
# Verilator build and run for the control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_control_unit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
